// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module dispatch_tb -o dispatch_sim

out=$(./obj_dir/dispatch_sim || true)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// ==== src.f ====
+incdir+src
src/dispatch_pkg.sv
src/issue_front.sv
src/thread_map.sv
src/instr_memory.sv
src/thread_dispatch.sv
src/dispatch_top.sv
verification/dispatch_tb.sv

// ==== src/dispatch_macros.svh ====
/* Dispatch widths and depths */

`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// Thread ID and issue number width
`define DISP_ID_W       8

// Instruction memory address and thread length
`define DISP_ADDR_W     10
`define DISP_LEN_W      10

// Instruction and header word width
`define DISP_WORD_W     32

// Table and memory sizes
`define DISP_THREADS    16
`define DISP_IMEM_DEPTH 1024

`endif

// ==== src/dispatch_pkg.sv ====
/* Dispatch shared types */

`default_nettype none

`include "dispatch_macros.svh"

package dispatch_pkg;

	typedef logic [`DISP_ID_W-1:0]   id_t;
	typedef logic [`DISP_ADDR_W-1:0] addr_t;
	typedef logic [`DISP_LEN_W-1:0]  len_t;
	typedef logic [`DISP_WORD_W-1:0] word_t;

	//////////////////////////////////////////////////
	// Thread map entry
	typedef struct packed {
		addr_t base;   // First instruction
		len_t  length; // Instruction count, never zero
	} map_entry_t;

	//////////////////////////////////////////////////
	// Host program write port
	typedef enum logic {
		PROG_MAP,
		PROG_IMEM
	} prog_target_e;

	typedef struct packed {
		logic         wr;     // One-cycle strobe
		prog_target_e target;
		addr_t        addr;   // Map index or memory address
		word_t        data;
	} prog_wr_t;

	// Stream to the thread processing units
	typedef struct packed {
		logic  valid;
		word_t word;
	} instr_out_t;

	typedef enum logic [2:0] {
		DSP_IDLE,
		DSP_LOOKUP,
		DSP_SEND_ID,
		DSP_SEND_ISSUE,
		DSP_SEND_LEN,
		DSP_SEND_INSTRS
	} dispatch_state_e;

endpackage

`default_nettype wire

// ==== src/dispatch_top.sv ====
/* Dispatch stage top */

`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
	input  logic                     clock,
	input  logic                     reset,
	input  dispatch_pkg::prog_wr_t   prog_wr,
	input  logic                     issue_req,
	input  dispatch_pkg::id_t        issue_thread,
	output logic                     issue_ack,
	output dispatch_pkg::instr_out_t instr_out,
	output logic                     send_thread,
	output logic                     end_send
);
	import dispatch_pkg::*;

	// Front end to dispatch
	logic disp_start;
	id_t  disp_thread;
	id_t  disp_issue_no;
	logic busy;

	// Map lookup
	logic       lookup_req;
	id_t        lookup_thread;
	logic       lookup_ack;
	map_entry_t lookup_entry;

	// Program fetch
	logic  imem_rd;
	addr_t imem_addr;
	word_t imem_data;

	issue_front front_i (
		.clock         (clock),
		.reset         (reset),
		.issue_req     (issue_req),
		.issue_thread  (issue_thread),
		.issue_ack     (issue_ack),
		.busy          (busy),
		.disp_start    (disp_start),
		.disp_thread   (disp_thread),
		.disp_issue_no (disp_issue_no)
	);

	thread_map map_i (
		.clock         (clock),
		.reset         (reset),
		.prog_wr       (prog_wr),
		.lookup_req    (lookup_req),
		.lookup_thread (lookup_thread),
		.lookup_ack    (lookup_ack),
		.lookup_entry  (lookup_entry)
	);

	instr_memory imem_i (
		.clock     (clock),
		.prog_wr   (prog_wr),
		.imem_rd   (imem_rd),
		.imem_addr (imem_addr),
		.imem_data (imem_data)
	);

	thread_dispatch dispatch_i (
		.clock         (clock),
		.reset         (reset),
		.disp_start    (disp_start),
		.disp_thread   (disp_thread),
		.disp_issue_no (disp_issue_no),
		.busy          (busy),
		.lookup_req    (lookup_req),
		.lookup_thread (lookup_thread),
		.lookup_ack    (lookup_ack),
		.lookup_entry  (lookup_entry),
		.imem_rd       (imem_rd),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.instr_out     (instr_out),
		.send_thread   (send_thread),
		.end_send      (end_send)
	);

endmodule

`default_nettype wire

// ==== src/instr_memory.sv ====
/* Thread program memory */

`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module instr_memory (
	input  logic                   clock,
	input  dispatch_pkg::prog_wr_t prog_wr,
	input  logic                   imem_rd,
	input  dispatch_pkg::addr_t    imem_addr,
	output dispatch_pkg::word_t    imem_data
);
	import dispatch_pkg::*;

	word_t mem [`DISP_IMEM_DEPTH];
	logic  mem_wr;

	assign mem_wr = prog_wr.wr && prog_wr.target == PROG_IMEM;

	// Host program load
	always_ff @(posedge clock) begin
		if (mem_wr)
			mem[prog_wr.addr] <= prog_wr.data;
	end

	// Registered read, data one cycle after rd
	always_ff @(posedge clock) begin
		if (imem_rd)
			imem_data <= mem[imem_addr];
	end

endmodule

`default_nettype wire

// ==== src/issue_front.sv ====
/* Host issue front end */

`timescale 1ns/1ps
`default_nettype none

module issue_front (
	input  logic              clock,
	input  logic              reset,
	input  logic              issue_req,
	input  dispatch_pkg::id_t issue_thread,
	output logic              issue_ack,
	input  logic              busy,
	output logic              disp_start,
	output dispatch_pkg::id_t disp_thread,
	output dispatch_pkg::id_t disp_issue_no
);
	import dispatch_pkg::*;

	id_t  issue_cnt; // Next issue number
	logic accept;

	// Fresh request only, with ack low and dispatch idle
	assign accept = issue_req && !issue_ack && !busy;

	// Four-phase handshake and issue counter
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_ack  <= 1'b0;
			disp_start <= 1'b0;
			issue_cnt  <= '0;
		end else begin
			disp_start <= accept; // Same cycle as ack rising
			if (accept) begin
				issue_ack <= 1'b1;
				issue_cnt <= issue_cnt + 1'b1; // Wraps at 8 bits
			end else if (!issue_req) begin
				issue_ack <= 1'b0;
			end
		end
	end

	// Request payload handed to dispatch
	always_ff @(posedge clock) begin
		if (accept) begin
			disp_thread   <= issue_thread;
			disp_issue_no <= issue_cnt;
		end
	end

	// Host must see ack until it lets go of req
	ack_held_a: assert property (@(posedge clock) disable iff (reset)
		(issue_ack && issue_req) |=> issue_ack);

	// Start only reaches an idle dispatch
	start_idle_a: assert property (@(posedge clock) disable iff (reset)
		disp_start |-> !busy);

endmodule

`default_nettype wire

// ==== src/thread_dispatch.sv ====
/* Thread dispatch controller */

`timescale 1ns/1ps
`default_nettype none

module thread_dispatch (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     disp_start,
	input  dispatch_pkg::id_t        disp_thread,
	input  dispatch_pkg::id_t        disp_issue_no,
	output logic                     busy,
	output logic                     lookup_req,
	output dispatch_pkg::id_t        lookup_thread,
	input  logic                     lookup_ack,
	input  dispatch_pkg::map_entry_t lookup_entry,
	output logic                     imem_rd,
	output dispatch_pkg::addr_t      imem_addr,
	input  dispatch_pkg::word_t      imem_data,
	output dispatch_pkg::instr_out_t instr_out,
	output logic                     send_thread,
	output logic                     end_send
);
	import dispatch_pkg::*;

	dispatch_state_e state;

	// Thread being dispatched
	id_t   r_thread;
	id_t   r_issue_no;
	len_t  r_length;  // For the header word
	len_t  r_remain;  // Reads still to issue
	addr_t r_addr;

	// Output stage
	logic  hdr_valid;
	word_t hdr_word;
	logic  rd_d1;     // Memory word on imem_data

	logic  sending;
	logic  last_read;
	logic  got_entry;

	assign sending   = state == DSP_SEND_INSTRS;
	assign last_read = sending && (r_remain == len_t'(1));
	assign got_entry = (state == DSP_LOOKUP) && lookup_ack;

	assign lookup_req    = state == DSP_LOOKUP;
	assign lookup_thread = r_thread;

	assign imem_rd     = sending;
	assign imem_addr   = r_addr;
	assign send_thread = sending;
	assign end_send    = last_read;

	// Stays up through the trailing word
	assign busy = (state != DSP_IDLE) || rd_d1;

	// Memory data goes out one cycle behind its read
	assign instr_out.valid = hdr_valid || rd_d1;
	assign instr_out.word  = hdr_valid ? hdr_word : imem_data;

	//////////////////////////////////////////////////
	// Header output stage

	always_ff @(posedge clock) begin
		if (reset) begin
			hdr_valid <= 1'b0;
			rd_d1     <= 1'b0;
		end else begin
			hdr_valid <= state inside {DSP_SEND_ID, DSP_SEND_ISSUE, DSP_SEND_LEN};
			rd_d1     <= sending;
		end
	end

	// Order is ID, issue number, length
	always_ff @(posedge clock) begin
		case (state)
			DSP_SEND_ID:    hdr_word <= word_t'(r_thread);
			DSP_SEND_ISSUE: hdr_word <= word_t'(r_issue_no);
			default:        hdr_word <= word_t'(r_length);
		endcase
	end

	//////////////////////////////////////////////////
	// Request and map capture

	always_ff @(posedge clock) begin
		if (disp_start && state == DSP_IDLE) begin
			r_thread   <= disp_thread;
			r_issue_no <= disp_issue_no;
		end
	end

	always_ff @(posedge clock) begin
		if (got_entry) begin
			r_addr   <= lookup_entry.base;
			r_length <= lookup_entry.length;
		end else if (sending) begin
			r_addr <= r_addr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			r_remain <= '0;
		else if (got_entry)
			r_remain <= lookup_entry.length;
		else if (sending)
			r_remain <= r_remain - 1'b1;
	end

	//////////////////////////////////////////////////
	// Dispatch FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= DSP_IDLE;
		end else begin
			case (state)
				DSP_IDLE: begin
					if (disp_start)
						state <= DSP_LOOKUP;
				end
				DSP_LOOKUP: begin
					if (lookup_ack)
						state <= DSP_SEND_ID;
				end
				DSP_SEND_ID:    state <= DSP_SEND_ISSUE;
				DSP_SEND_ISSUE: state <= DSP_SEND_LEN;
				DSP_SEND_LEN:   state <= DSP_SEND_INSTRS;
				DSP_SEND_INSTRS: begin
					if (last_read)
						state <= DSP_IDLE;
				end
				default: state <= DSP_IDLE;
			endcase
		end
	end

	// Only the word read with end_send may trail into idle
	quiet_idle_a: assert property (@(posedge clock) disable iff (reset)
		(instr_out.valid && state inside {DSP_IDLE, DSP_LOOKUP}) |-> $past(end_send));

endmodule

`default_nettype wire

// ==== src/thread_map.sv ====
/* Thread map table */

`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module thread_map (
	input  logic                     clock,
	input  logic                     reset,
	input  dispatch_pkg::prog_wr_t   prog_wr,
	input  logic                     lookup_req,
	input  dispatch_pkg::id_t        lookup_thread,
	output logic                     lookup_ack,
	output dispatch_pkg::map_entry_t lookup_entry
);
	import dispatch_pkg::*;

	localparam int IDX_W = $clog2(`DISP_THREADS);

	map_entry_t       map_q [`DISP_THREADS];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic             take_req;

	assign wr_idx   = prog_wr.addr[IDX_W-1:0];
	assign rd_idx   = lookup_thread[IDX_W-1:0];
	assign take_req = lookup_req && !lookup_ack;

	// Base in data[9:0], length in data[25:16]
	always_ff @(posedge clock) begin
		if (prog_wr.wr && prog_wr.target == PROG_MAP) begin
			map_q[wr_idx] <= '{
				base:   prog_wr.data[`DISP_ADDR_W-1:0],
				length: prog_wr.data[16 +: `DISP_LEN_W]
			};
		end
	end

	// Lookup handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_ack <= 1'b0;
		end else if (take_req) begin
			lookup_ack <= 1'b1;
		end else if (!lookup_req) begin
			lookup_ack <= 1'b0; // Return to zero
		end
	end

	// Entry held while ack is up
	always_ff @(posedge clock) begin
		if (take_req)
			lookup_entry <= map_q[rd_idx];
	end

	// No ack out of nowhere
	no_stray_ack_a: assert property (@(posedge clock) disable iff (reset)
		(!lookup_req && !lookup_ack) |=> !lookup_ack);

endmodule

`default_nettype wire

// ==== verification/dispatch_stim.txt ====
# M <thread> <data: base in [9:0], length in [25:16]>   P <address> <instruction word>
# I <thread>   O <thread> <thread requested during its stream>   R reset check
M 3 00040010
M 5 00030012
M 9 00010020
M c 000203fe
P 010 a0000010
P 011 a0000011
P 012 b1c2d3e4
P 013 0000ffff
P 014 5a5a0014
P 020 12345678
P 3fe 7f00003e
P 3ff 80000001
R
I 3
I 3
I 5
I 9
O c 5
R
I 9

// ==== verification/dispatch_tb.sv ====
/* Dispatch stage testbench */

`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module dispatch_tb;
	import dispatch_pkg::*;

	localparam int IDX_W = $clog2(`DISP_THREADS);

	logic       clock = 1'b0;
	logic       reset;
	prog_wr_t   prog_wr;
	logic       issue_req;
	id_t        issue_thread;
	logic       issue_ack;
	instr_out_t instr_out;
	logic       send_thread;
	logic       end_send;

	// Reference copies of the map and memory
	map_entry_t map_model [`DISP_THREADS];
	word_t      mem_model [`DISP_IMEM_DEPTH];
	id_t        issue_model; // Next expected issue number
	id_t        last_thread; // Launched by the reset check
	bit         have_thread = 1'b0;

	// Commands from the stim file
	logic [7:0] cmd_q [$];
	word_t      arg_a [$];
	word_t      arg_b [$];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;
	int cycle_limit = 40; // Initial reset and margin

	dispatch_top dut_i (.*);

	always #5 clock = ~clock;

	// Watchdog sized from the stimulus
	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Checks and reporting

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("Error at t=%0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string what, input int err0);
		tests++;
		if (errors == err0) begin
			$display("test %0d %s: ok", tests, what);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests, what, errors - err0);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus file

	task automatic read_stim();
		int         fd;
		string      line;
		logic [7:0] cmd;
		word_t      a;
		word_t      b;
		len_t       len_seen [`DISP_THREADS];
		fd = $fopen("verification/dispatch_stim.txt", "r");
		if (fd == 0) begin
			check_true(1'b0, "cannot open the stimulus file verification/dispatch_stim.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.getc(0) inside {"M", "P", "I", "O", "R"}) begin
					a = '0;
					b = '0;
					void'($sscanf(line, "%c %h %h", cmd, a, b));
					cmd_q.push_back(cmd);
					arg_a.push_back(a);
					arg_b.push_back(b);
					// Lengths known so far give the timeout
					case (cmd)
						"M": len_seen[a[IDX_W-1:0]] = b[16 +: `DISP_LEN_W];
						"I": cycle_limit += int'(len_seen[a[IDX_W-1:0]]) + 20;
						"O": cycle_limit += int'(len_seen[a[IDX_W-1:0]])
							+ int'(len_seen[b[IDX_W-1:0]]) + 40;
						"R": cycle_limit += 20;
						default: cycle_limit += 10;
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////////////////////////
	// Command tasks, each entered and left on a falling edge

	task automatic program_write(input prog_target_e tgt, input word_t addr, input word_t data);
		prog_wr = '{wr: 1'b1, target: tgt, addr: addr_t'(addr), data: data};
		if (tgt == PROG_MAP) begin
			map_model[addr[IDX_W-1:0]].base   = data[`DISP_ADDR_W-1:0];
			map_model[addr[IDX_W-1:0]].length = data[16 +: `DISP_LEN_W];
			last_thread = id_t'(addr);
			have_thread = 1'b1;
		end else begin
			mem_model[addr[`DISP_ADDR_W-1:0]] = data;
		end
		@(negedge clock);
		prog_wr.wr = 1'b0;
	endtask

	task automatic check_reset();
		int err0;
		err0 = errors;
		// Reset lands in the middle of a running stream
		if (have_thread) begin
			issue_thread = last_thread;
			issue_req    = 1'b1;
			while (!send_thread)
				@(negedge clock);
		end
		reset     = 1'b1;
		issue_req = 1'b0;
		@(negedge clock);
		check_true(!issue_ack && !instr_out.valid && !send_thread && !end_send,
			"outputs not cleared by reset during a stream");
		repeat (4) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_true(!issue_ack && !instr_out.valid && !send_thread && !end_send,
			"outputs not idle after reset");
		issue_model = '0;
		report_test("reset", err0);
	endtask

	// Handshake plus the whole stream, optionally raising the next request early
	task automatic run_issue(input id_t thread, input bit hold_next, input id_t next_thread);
		map_entry_t ent;
		addr_t      addr;
		word_t      exp_q [$];
		int         n_words;
		int         n_end;
		int         n_send;
		int         phase;
		int         err0;
		ent  = map_model[thread[IDX_W-1:0]];
		addr = ent.base;
		exp_q.push_back(word_t'(thread)); // Header order ID, issue, length
		exp_q.push_back(word_t'(issue_model));
		exp_q.push_back(word_t'(ent.length));
		repeat (int'(ent.length)) begin
			exp_q.push_back(mem_model[addr]);
			addr = addr + 1'b1;
		end
		err0    = errors;
		n_words = 0;
		n_end   = 0;
		n_send  = 0;
		phase   = 0;
		if (!issue_req) begin
			issue_thread = thread;
			issue_req    = 1'b1;
		end
		while (phase < 4 || n_words < exp_q.size()) begin
			@(negedge clock);
			if (instr_out.valid) begin
				if (n_words < exp_q.size())
					check_value("instr_out.word", instr_out.word, exp_q[n_words]);
				n_words++;
			end
			if (send_thread)
				n_send++;
			if (end_send) begin
				n_end++;
				// Last word follows one cycle later
				check_true(n_words == exp_q.size() - 1,
					"end_send did not pulse on the last instruction read");
			end
			case (phase)
				0: phase = issue_ack ? 1 : 0;
				1, 2: begin // Req held two more cycles
					check_true(issue_ack, "issue_ack fell while issue_req was still high");
					phase++;
					if (phase == 3)
						issue_req = 1'b0;
				end
				3: begin
					check_true(!issue_ack, "issue_ack stayed high after issue_req was dropped");
					if (hold_next) begin
						issue_thread = next_thread;
						issue_req    = 1'b1;
					end
					phase = 4;
				end
				default: begin
					if (hold_next)
						check_true(!issue_ack, "held request acknowledged during a stream");
				end
			endcase
		end
		@(negedge clock);
		check_true(!instr_out.valid, "valid word after the end of the stream");
		check_value("end_send pulse count", word_t'(n_end), word_t'(1));
		check_value("send_thread cycle count", word_t'(n_send), word_t'(ent.length));
		issue_model = issue_model + 1'b1;
		report_test($sformatf("issue thread %0d length %0d", thread, ent.length), err0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset        = 1'b1;
		issue_req    = 1'b0;
		issue_thread = '0;
		prog_wr      = '0;
		issue_model  = '0;
		read_stim();
		repeat (5) @(negedge clock);
		reset = 1'b0;
		foreach (cmd_q[k]) begin
			case (cmd_q[k])
				"M": program_write(PROG_MAP, arg_a[k], arg_b[k]);
				"P": program_write(PROG_IMEM, arg_a[k], arg_b[k]);
				"I": run_issue(id_t'(arg_a[k]), 1'b0, '0);
				"O": begin
					run_issue(id_t'(arg_a[k]), 1'b1, id_t'(arg_b[k]));
					run_issue(id_t'(arg_b[k]), 1'b0, '0);
				end
				default: check_reset();
			endcase
		end
		@(negedge clock);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0 && tests > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
